// File: common/imuldiv_pkg.sv
/*
 * imuldiv shared definitions
 * operand widths, engine FSM encoding, request/response structs, result union
 */
package imuldiv_pkg;

  // --------------------
  // widths

  // operand width
  localparam int XLEN  = 32;
  // tag width, enough to tell apart the requests a caller keeps outstanding
  localparam int TAG_W = 4;
  // one iteration per operand bit
  localparam int STEPS = XLEN;
  // down counter runs STEPS-1 .. 0
  localparam int CNT_W = 5;

  // --------------------
  // engine FSM encoding, shared by both engines

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_CALC = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  // --------------------
  // messages

  // request word
  // mul uses a*b, div uses a/b
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             is_div;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
  } imuldiv_req_t;

  // divide result, remainder in the upper half
  typedef struct packed {
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quot;
  } imuldiv_divres_t;

  // one 64-bit result word, read as a product or as quot/rem
  typedef union packed {
    logic [2*XLEN-1:0] product;
    imuldiv_divres_t   divres;
  } imuldiv_result_u;

  // response word
  // is_div picks which view of result is meaningful
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             is_div;
    imuldiv_result_u  result;
  } imuldiv_resp_t;

endpackage

// File: imuldiv_mul/imuldiv_mul_iterative.sv
/*
 * iterative signed multiplier
 * shift-add on operand magnitudes, one multiplier bit per cycle, sign fixed at the end
 */
`timescale 1ns/10ps

module imuldiv_mul_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);
  import imuldiv_pkg::*;

  logic [1:0]        state;
  logic [CNT_W-1:0]  cnt;
  logic              out_val;
  logic              accept;
  logic              fire;

  logic [XLEN-1:0]   a_mag;
  logic [XLEN-1:0]   b_mag;
  logic [2*XLEN-1:0] mcand;
  logic [XLEN-1:0]   mplier;
  logic [2*XLEN-1:0] acc;
  logic              neg;
  logic [TAG_W-1:0]  tag;
  imuldiv_result_u   result_q;

  assign accept  = req_val && req_rdy;
  assign fire    = resp_val && resp_rdy;
  assign req_rdy = (state == ST_IDLE);

  // operand magnitudes, -2^31 maps to 2^31 as unsigned
  assign a_mag = req.a[XLEN-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[XLEN-1] ? (~req.b + 1'b1) : req.b;

  // --------------------
  // control FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      out_val <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_CALC;
            cnt   <= CNT_W'(STEPS - 1);
          end
        end
        ST_CALC: begin
          // last step happens on the edge that sees cnt at zero
          cnt <= cnt - 1'b1;
          if (cnt == '0) state <= ST_DONE;
        end
        ST_DONE: begin
          // first DONE cycle registers the signed result, then valid rises
          if (fire) begin
            state   <= ST_IDLE;
            out_val <= 1'b0;
          end else begin
            out_val <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // datapath

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{XLEN{1'b0}}, a_mag};
      mplier <= b_mag;
      acc    <= '0;
      neg    <= req.a[XLEN-1] ^ req.b[XLEN-1];
      tag    <= req.tag;
    end else if (state == ST_CALC) begin
      // add shifted multiplicand for each set multiplier bit
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end else if (state == ST_DONE && !out_val) begin
      // negate when exactly one operand was negative
      result_q.product <= neg ? (~acc + 1'b1) : acc;
    end
  end

  assign resp     = '{tag: tag, is_div: 1'b0, result: result_q};
  assign resp_val = out_val;

  // a stalled response holds still until the arbiter takes it
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp));

endmodule

// File: imuldiv_div/imuldiv_div_iterative.sv
/*
 * iterative signed divider
 * restoring division on magnitudes, quotient and remainder signs fixed at the end
 */
`timescale 1ns/10ps

module imuldiv_div_iterative (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);
  import imuldiv_pkg::*;

  logic [1:0]       state;
  logic [CNT_W-1:0] cnt;
  logic             out_val;
  logic             accept;
  logic             fire;

  logic [XLEN-1:0]  a_mag;
  logic [XLEN-1:0]  b_mag;
  // dividend bits leave at the top, quotient bits enter at the bottom
  logic [XLEN-1:0]  dq;
  logic [XLEN-1:0]  dsr;
  logic [XLEN:0]    prem;
  logic [XLEN:0]    shifted;
  logic             rem_geq;
  logic             a_neg;
  logic             q_neg;
  logic             dbz;
  logic [TAG_W-1:0] tag;
  imuldiv_result_u  result_q;

  assign accept  = req_val && req_rdy;
  assign fire    = resp_val && resp_rdy;
  assign req_rdy = (state == ST_IDLE);

  assign a_mag = req.a[XLEN-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[XLEN-1] ? (~req.b + 1'b1) : req.b;

  // next dividend bit into the partial remainder
  assign shifted = {prem[XLEN-1:0], dq[XLEN-1]};
  assign rem_geq = (shifted >= {1'b0, dsr});

  // --------------------
  // control FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      cnt     <= '0;
      out_val <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state <= ST_CALC;
            cnt   <= CNT_W'(STEPS - 1);
          end
        end
        ST_CALC: begin
          // full count even for a zero divisor, latency stays uniform
          cnt <= cnt - 1'b1;
          if (cnt == '0) state <= ST_DONE;
        end
        ST_DONE: begin
          if (fire) begin
            state   <= ST_IDLE;
            out_val <= 1'b0;
          end else begin
            out_val <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // --------------------
  // datapath

  always_ff @(posedge clk) begin
    if (accept) begin
      dq    <= a_mag;
      dsr   <= b_mag;
      prem  <= '0;
      a_neg <= req.a[XLEN-1];
      q_neg <= req.a[XLEN-1] ^ req.b[XLEN-1];
      dbz   <= (req.b == '0);
      tag   <= req.tag;
    end else if (state == ST_CALC) begin
      // subtract when it fits, otherwise keep the shifted remainder
      prem <= rem_geq ? (shifted - {1'b0, dsr}) : shifted;
      dq   <= {dq[XLEN-2:0], rem_geq};
    end else if (state == ST_DONE && !out_val) begin
      // zero divisor gives all ones, no sign fix on the quotient
      if (dbz) result_q.divres.quot <= '1;
      else result_q.divres.quot <= q_neg ? (~dq + 1'b1) : dq;
      // remainder follows the dividend sign
      // with a zero divisor prem holds the full dividend magnitude, so this is the dividend
      result_q.divres.rem <= a_neg ? (~prem[XLEN-1:0] + 1'b1) : prem[XLEN-1:0];
    end
  end

  assign resp     = '{tag: tag, is_div: 1'b1, result: result_q};
  assign resp_val = out_val;

  // response frozen while waiting on the shared port
  resp_wait: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp));

endmodule

// File: verilog/imuldiv_req_dispatch.sv
/*
 * request dispatcher
 * steers each request to the multiplier or the divider by its is_div bit
 */
`timescale 1ns/10ps

module imuldiv_req_dispatch (
  input  logic req_val,
  output logic req_rdy,
  input  logic is_div,
  output logic mul_req_val,
  output logic div_req_val,
  input  logic mul_req_rdy,
  input  logic div_req_rdy
);

  // --------------------
  // steering

  // only the selected engine sees a valid
  assign mul_req_val = req_val && !is_div;
  assign div_req_val = req_val && is_div;

  // rdy comes from the selected engine only
  // a busy divider does not stall multiplies and vice versa
  assign req_rdy = is_div ? div_req_rdy : mul_req_rdy;

  // --------------------
  // checks

  // an unknown is_div leaves the engine valids not one-hot
  always_comb begin
    if (req_val) begin
      steer_known: assert (!$isunknown(is_div))
        else $error("request valid with unknown is_div");
    end
  end

endmodule

// File: verilog/imuldiv_resp_arbiter.sv
/*
 * response arbiter
 * round-robin grant of the shared response port, held until the response is taken
 */
`timescale 1ns/10ps

module imuldiv_resp_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_resp_t mul_resp,
  input  imuldiv_pkg::imuldiv_resp_t div_resp,
  input  logic                       mul_resp_val,
  input  logic                       div_resp_val,
  output logic                       mul_resp_rdy,
  output logic                       div_resp_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);

  logic last_was_div;
  logic lock;
  logic lock_div;
  logic grant_div;
  logic fire;

  // --------------------
  // grant

  always_comb begin
    if (lock) begin
      // keep the engine whose response is already on the port
      grant_div = lock_div;
    end else if (mul_resp_val && div_resp_val) begin
      // tie goes to whoever did not win last time
      grant_div = !last_was_div;
    end else begin
      grant_div = div_resp_val;
    end
  end

  // data path mux adds no cycles
  assign resp     = grant_div ? div_resp : mul_resp;
  assign resp_val = grant_div ? div_resp_val : mul_resp_val;
  assign fire     = resp_val && resp_rdy;

  // rdy goes back to the granted engine only
  assign mul_resp_rdy = resp_rdy && !grant_div;
  assign div_resp_rdy = resp_rdy && grant_div;

  // --------------------
  // round-robin and lock state

  always_ff @(posedge clk) begin
    if (reset) begin
      // multiplier wins the first tie
      last_was_div <= 1'b1;
      lock         <= 1'b0;
      lock_div     <= 1'b0;
    end else if (fire) begin
      last_was_div <= grant_div;
      lock         <= 1'b0;
    end else if (resp_val) begin
      lock     <= 1'b1;
      lock_div <= grant_div;
    end
  end

  // a stalled response keeps its grant, so rdy reaches the same engine when it is taken
  grant_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(grant_div));

endmodule

// File: verilog/imuldiv_unit.sv
/*
 * imuldiv top level
 * dispatcher, multiplier and divider engines, shared response arbiter
 */
`timescale 1ns/10ps

module imuldiv_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  imuldiv_pkg::imuldiv_req_t  req,
  input  logic                       req_val,
  output logic                       req_rdy,
  output imuldiv_pkg::imuldiv_resp_t resp,
  output logic                       resp_val,
  input  logic                       resp_rdy
);
  import imuldiv_pkg::*;

  // request side
  logic          mul_req_val;
  logic          div_req_val;
  logic          mul_req_rdy;
  logic          div_req_rdy;

  // engine responses toward the arbiter
  imuldiv_resp_t mul_resp;
  imuldiv_resp_t div_resp;
  logic          mul_resp_val;
  logic          div_resp_val;
  logic          mul_resp_rdy;
  logic          div_resp_rdy;

  // --------------------
  // request steering

  imuldiv_req_dispatch u_dispatch (
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .is_div      (req.is_div),
    .mul_req_val (mul_req_val),
    .div_req_val (div_req_val),
    .mul_req_rdy (mul_req_rdy),
    .div_req_rdy (div_req_rdy)
  );

  // --------------------
  // engines, both see the same request word

  imuldiv_mul_iterative u_mul (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_div_iterative u_div (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp     (div_resp),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

  // --------------------
  // shared response port

  imuldiv_resp_arbiter u_arb (
    .clk          (clk),
    .reset        (reset),
    .mul_resp     (mul_resp),
    .div_resp     (div_resp),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy),
    .resp         (resp),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy)
  );

endmodule

// File: verif/imuldiv_tb.sv
/*
 * imuldiv testbench
 * LFSR stimulus through the unit, reference model by tag, back-pressure checks
 */
`timescale 1ns/10ps

module imuldiv_tb;
  import imuldiv_pkg::*;

  typedef enum int {MUL_ONLY, DIV_ONLY, DIV_ZERO, ALTERNATE, MIXED} mix_t;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp;
  logic          resp_val;
  logic          resp_rdy;

  logic [31:0]      lfsr;
  logic [TAG_W-1:0] next_tag;
  // expected response and in-flight flag per tag
  imuldiv_resp_t    expect_tbl [1<<TAG_W];
  bit               outstanding [1<<TAG_W];
  int               pending;
  int               errors;
  int               tests_passed;
  int               tests_failed;
  int               both_busy;
  bit               was_stalled;
  imuldiv_resp_t    stalled_resp;

  imuldiv_unit uut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // random source

  // taps 32,22,2,1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // half of the picks are corner values
  function automatic logic [31:0] pick_operand();
    logic [2:0] sel;
    sel = 3'(take_bits(3));
    case (sel)
      3'd0: return 32'd0;
      3'd1: return 32'd1;
      3'd2: return 32'hffff_ffff;
      3'd3: return 32'h8000_0000;
      default: return take_bits(32);
    endcase
  endfunction

  // small divisors of either sign, or a full random word
  function automatic logic [31:0] pick_divisor();
    logic [31:0] d;
    if (take_bits(1) != 0) begin
      d = take_bits(3) + 32'd1;
      if (take_bits(1) != 0) d = -d;
    end else begin
      d = take_bits(32);
    end
    return d;
  endfunction

  function automatic imuldiv_req_t make_req(input mix_t kind, input int idx,
                                            input logic [TAG_W-1:0] tag);
    imuldiv_req_t r;
    r.tag = tag;
    case (kind)
      MUL_ONLY: r.is_div = 1'b0;
      DIV_ONLY, DIV_ZERO: r.is_div = 1'b1;
      // strict alternation keeps both engines busy
      ALTERNATE: r.is_div = idx[0];
      default: r.is_div = (take_bits(1) != 0);
    endcase
    r.a = pick_operand();
    r.b = r.is_div ? pick_divisor() : pick_operand();
    if (kind == DIV_ZERO) r.b = '0;
    // overflow case first in the divide test
    if (kind == DIV_ONLY && idx == 0) begin
      r.a = 32'h8000_0000;
      r.b = 32'hffff_ffff;
    end
    return r;
  endfunction

  // --------------------
  // reference model

  // 64-bit signed arithmetic, so -2^31 / -1 wraps back to 0x80000000
  function automatic imuldiv_resp_t expected_resp(input imuldiv_req_t r);
    imuldiv_resp_t e;
    longint sa;
    longint sb;
    e = '0;
    sa = longint'($signed(r.a));
    sb = longint'($signed(r.b));
    e.tag = r.tag;
    e.is_div = r.is_div;
    if (!r.is_div) begin
      e.result.product = sa * sb;
    end else if (r.b == '0) begin
      e.result.divres.quot = '1;
      e.result.divres.rem = r.a;
    end else begin
      // truncating divide, remainder keeps the dividend sign
      e.result.divres.quot = 32'(sa / sb);
      e.result.divres.rem = 32'(sa % sb);
    end
    return e;
  endfunction

  // --------------------
  // compare tasks

  task automatic check_product(input string name, input imuldiv_result_u act,
                               input logic [63:0] exp);
    if (act.product !== exp) begin
      errors++;
      $display("ERROR %s: expected product %h, actual %h", name, exp, act.product);
    end
  endtask

  task automatic check_divres(input string name, input imuldiv_divres_t exp,
                              input imuldiv_divres_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected quot %h rem %h, actual quot %h rem %h",
               name, exp.quot, exp.rem, act.quot, act.rem);
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_W-1:0] tag);
    if (!outstanding[tag]) begin
      errors++;
      $display("%s: response carries tag %0d, which was not outstanding", name, tag);
    end
  endtask

  task automatic flag_equals(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic resp_unchanged(input string name, input imuldiv_resp_t exp,
                                input imuldiv_resp_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s stalled resp: expected %h, actual %h", name, exp, act);
    end
  endtask

  // --------------------
  // scoreboard

  task automatic record_request(input string name);
    if (outstanding[req.tag]) begin
      errors++;
      $display("%s: tag %0d issued again while still outstanding", name, req.tag);
    end
    expect_tbl[req.tag] = expected_resp(req);
    outstanding[req.tag] = 1'b1;
    pending++;
  endtask

  task automatic take_response(input string name);
    imuldiv_resp_t exp;
    string         where;
    where = $sformatf("%s tag %0d", name, resp.tag);
    check_tag(where, resp.tag);
    if (outstanding[resp.tag]) begin
      exp = expect_tbl[resp.tag];
      outstanding[resp.tag] = 1'b0;
      pending--;
      flag_equals({where, " is_div"}, exp.is_div, resp.is_div);
      if (exp.is_div) check_divres(where, exp.result.divres, resp.result.divres);
      else check_product(where, resp.result, exp.result.product);
    end
  endtask

  task automatic report_test(input string name, input int count, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %-12s %0d requests, pass", name, count);
    end else begin
      tests_failed++;
      $display("test %-12s %0d requests, fail with %0d errors", name, count,
               errors - errs_before);
    end
  endtask

  // drive at posedge+1, sample at negedge where every handshake is settled
  task automatic run_test(input string name, input mix_t kind, input int count,
                          input bit stall);
    int issued;
    int errs_before;
    int hold_left;
    bit have_req;
    issued = 0;
    errs_before = errors;
    hold_left = 0;
    have_req = 1'b0;
    both_busy = 0;
    while (issued < count || have_req || pending != 0) begin
      @(posedge clk);
      #1;
      if (!have_req && issued < count) begin
        req = make_req(kind, issued, next_tag);
        req_val = 1'b1;
        next_tag = next_tag + 1'b1;
        issued++;
        have_req = 1'b1;
      end else if (!have_req) begin
        req_val = 1'b0;
      end
      // rdy toggles after a random run of 1..8 cycles
      if (!stall) begin
        resp_rdy = 1'b1;
      end else if (hold_left > 0) begin
        hold_left--;
      end else begin
        resp_rdy = !resp_rdy;
        hold_left = take_bits(3);
      end
      @(negedge clk);
      if (was_stalled) begin
        flag_equals({name, " resp_val held"}, 1'b1, resp_val);
        resp_unchanged(name, stalled_resp, resp);
      end
      was_stalled = resp_val && !resp_rdy;
      stalled_resp = resp;
      if (req_val && req_rdy) begin
        record_request(name);
        have_req = 1'b0;
      end
      if (resp_val && resp_rdy) take_response(name);
      if (pending == 2) both_busy++;
    end
    if (kind == ALTERNATE && both_busy == 0) begin
      errors++;
      $display("%s: the two engines were never busy at the same time", name);
    end
    report_test(name, count, errs_before);
  endtask

  // --------------------
  // main sequence

  initial begin
    int errs_before;
    lfsr = 32'h8c63;
    next_tag = '0;
    pending = 0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    was_stalled = 1'b0;
    stalled_resp = '0;
    for (int i = 0; i < (1 << TAG_W); i++) outstanding[i] = 1'b0;
    reset = 1'b1;
    req = '0;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle after reset
    errs_before = errors;
    repeat (4) begin
      @(negedge clk);
      flag_equals("reset resp_val", 1'b0, resp_val);
      flag_equals("reset req_rdy", 1'b1, req_rdy);
    end
    report_test("reset", 0, errs_before);

    run_test("multiply", MUL_ONLY, 100, 1'b0);
    run_test("divide", DIV_ONLY, 100, 1'b0);
    run_test("div_by_zero", DIV_ZERO, 20, 1'b0);
    run_test("overlap", ALTERNATE, 40, 1'b0);
    run_test("backpressure", MIXED, 40, 1'b1);

    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // cycle budget of 80 per request plus slack for reset and idle checks
  initial begin
    int cycles;
    int limit;
    limit = (100 + 100 + 20 + 40 + 40) * 80 + 200;
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: %0d cycles passed with responses still missing", limit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: sources.f
common/imuldiv_pkg.sv
imuldiv_mul/imuldiv_mul_iterative.sv
imuldiv_div/imuldiv_div_iterative.sv
verilog/imuldiv_req_dispatch.sv
verilog/imuldiv_resp_arbiter.sv
verilog/imuldiv_unit.sv
verif/imuldiv_tb.sv

// File: Makefile
# Verilator build and run of the imuldiv testbench

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module imuldiv_tb -f sources.f
	./obj_dir/Vimuldiv_tb > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
